// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module mem_stage_tb -f mem_stage.f -o sim_mem_stage
	./obj_dir/sim_mem_stage

clean:
	rm -rf obj_dir

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_stage_tb;

    localparam int NUM_INSTR = 60;
    localparam int RST_CYCLES = 4;
    localparam int MAX_CYCLES = 40 * NUM_INSTR + RST_CYCLES;
    localparam logic [31:0] RD_XOR = 32'h5a3c_96e1;

    typedef struct packed {
        logic [3:0][31:0] ops;
        logic [31:0]      addr;
        logic             ie;
        logic [3:0]       ie_type;
    } exp_t;

    logic clk, rst, valid_in, size_ovr_en, is_push, ie_in, out_stall, mem_ack;
    mem_stage_pkg::op_size_e opsize, size_ovr, mem_size;
    mem_stage_pkg::mem_rw_e  mem_rw;
    mem_stage_pkg::op_src_e  op1_sel, op2_sel, op3_sel, op4_sel;
    logic [31:0] mem_addr_in, seg_lim, reg_a, reg_b, reg_c, reg_d, imm, eip, mem_rdata;
    logic [3:0]  ie_type_in, ie_type_out;
    logic        mem_req, stall, valid_out, ie_out;
    logic [31:0] mem_addr, op1, op2, op3, op4, addr_out;

    exp_t        exp_q[$];
    exp_t        head, held_snap;
    logic [31:0] exp_rd_addr, resp_seed, stall_seed;
    logic [1:0]  exp_rd_size, resp_delay;
    logic        resp_pending, acc_q, vo_q, req_q, held_q, ack_q, exp_rd_en;
    int          cycles, consumed, rd_reqs, exp_reads;

    mem_stage DUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Timeout.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) stop_run("Run timed out before all instructions drained.");
    end

    // Random back-pressure from execute, high about one cycle in four.
    always @(posedge clk) begin
        stall_seed = xorshift(stall_seed);
        out_stall <= (stall_seed[1:0] == 2'd0);
    end

    // Memory responder with 0 to 3 cycles of ack delay.
    always @(posedge clk) begin
        if (rst) begin
            mem_ack      <= 1'b0;
            resp_pending <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!resp_pending) begin
                resp_seed = xorshift(resp_seed);
                resp_delay <= resp_seed[1:0] - 2'd1;
                resp_pending <= (resp_seed[1:0] != 2'd0);
                if (resp_seed[1:0] == 2'd0) begin
                    mem_ack   <= 1'b1;
                    mem_rdata <= mem_addr ^ RD_XOR;
                end
            end else if (resp_delay == 2'd0) begin
                mem_ack      <= 1'b1;
                mem_rdata    <= mem_addr ^ RD_XOR;
                resp_pending <= 1'b0;
            end else begin
                resp_delay <= resp_delay - 2'd1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0; // Phase 4.
        end
    end

    // Handshake, timing, hold and result checks.
    always @(posedge clk) begin
        acc_q  <= valid_in && !stall && !rst;
        vo_q   <= valid_out;
        req_q  <= mem_req;
        ack_q  <= mem_ack; // Ack as seen on the edge where req last moved.
        held_q <= valid_out && out_stall && !rst;
        held_snap <= {op4, op3, op2, op1, addr_out, ie_out, ie_type_out};
        if (!rst) begin
            if (mem_req && !req_q) begin
                assert (!ack_q) else stop_run("mem_req rose while mem_ack was still high.");
                assert (exp_rd_en)
                else stop_run("mem_req rose for an instruction with no read.");
                expect_value("mem_addr", exp_rd_addr, mem_addr);
                expect_value("mem_size", 32'(exp_rd_size), 32'(mem_size));
                rd_reqs <= rd_reqs + 1;
            end
            if (!mem_req && req_q) begin
                assert (ack_q) else stop_run("mem_req dropped before mem_ack arrived.");
            end
            if (valid_out && !vo_q) begin
                assert (acc_q) else stop_run("valid_out rose without an accepted instruction.");
            end
            if (acc_q) begin
                assert (valid_out) else stop_run("valid_out missing one cycle after accept.");
            end
            if (held_q) begin
                assert (valid_out) else stop_run("valid_out dropped while out_stall was high.");
                expect_value("held op1", held_snap.ops[0], op1);
                expect_value("held op2", held_snap.ops[1], op2);
                expect_value("held op3", held_snap.ops[2], op3);
                expect_value("held op4", held_snap.ops[3], op4);
                expect_value("held addr_out", held_snap.addr, addr_out);
                expect_value("held ie_out", 32'(held_snap.ie), 32'(ie_out));
                expect_value("held ie_type_out", 32'(held_snap.ie_type), 32'(ie_type_out));
            end
            if (valid_out && out_stall) begin
                assert (stall) else stop_run("stall low while the output was held.");
            end
            if (valid_out && !out_stall) begin
                assert (exp_q.size() > 0)
                else stop_run("Output produced with no instruction queued.");
                head = exp_q.pop_front();
                expect_value("op1", head.ops[0], op1);
                expect_value("op2", head.ops[1], op2);
                expect_value("op3", head.ops[2], op3);
                expect_value("op4", head.ops[3], op4);
                expect_value("addr_out", head.addr, addr_out);
                expect_value("ie_out", 32'(head.ie), 32'(ie_out));
                expect_value("ie_type_out", 32'(head.ie_type), 32'(ie_type_out));
                consumed <= consumed + 1;
            end
        end
    end

    initial begin
        logic [31:0] seed, bytes, addr;
        logic [32:0] last;
        logic [2:0]  sz, sel[4];
        logic        fault, rd;
        exp_t        e;
        rst = 1'b1;
        valid_in = 1'b0;
        opsize = mem_stage_pkg::SZ_BYTE;
        size_ovr_en = 1'b0;
        size_ovr = mem_stage_pkg::SZ_BYTE;
        mem_addr_in = '0;
        mem_rw = mem_stage_pkg::RW_NONE;
        is_push = 1'b0;
        seg_lim = '0;
        reg_a = '0;
        reg_b = '0;
        reg_c = '0;
        reg_d = '0;
        imm = '0;
        eip = '0;
        ie_in = 1'b0;
        op1_sel = mem_stage_pkg::SRC_REG_A;
        op2_sel = mem_stage_pkg::SRC_REG_A;
        op3_sel = mem_stage_pkg::SRC_REG_A;
        op4_sel = mem_stage_pkg::SRC_REG_A;
        ie_type_in = '0;
        out_stall = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        cycles = 0;
        consumed = 0;
        rd_reqs = 0;
        exp_reads = 0;
        exp_rd_en = 1'b0;
        seed = 32'd29;
        resp_seed = 32'd29 ^ 32'h1234;
        stall_seed = 32'd29 ^ 32'h8765;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!valid_out && !mem_req && !stall && !ie_out)
        else stop_run("Outputs not low after reset.");
        for (int i = 0; i < NUM_INSTR; i++) begin
            seed = xorshift(seed);
            addr = seed;
            seed = xorshift(seed);
            sz = (seed[1:0] == 2'd3) ? 3'd2 : {1'b0, seed[1:0]};
            opsize <= mem_stage_pkg::op_size_e'(seed[3:2] == 2'd3 ? 2'd1 : seed[3:2]);
            size_ovr_en <= seed[4];
            size_ovr <= mem_stage_pkg::op_size_e'(sz[1:0]);
            if (!seed[4]) sz = {1'b0, (seed[3:2] == 2'd3) ? 2'd1 : seed[3:2]};
            bytes = (sz == 3'd0) ? 32'd1 : (sz == 3'd1) ? 32'd2 : 32'd4;
            is_push <= (seed[6:5] == 2'd0);
            if (seed[6:5] == 2'd0) addr = addr - bytes; // Push pre-decrement.
            mem_addr_in <= (seed[6:5] == 2'd0) ? addr + bytes : addr;
            mem_rw <= mem_stage_pkg::mem_rw_e'(seed[8:7] == 2'd3 ? 2'd1 : seed[8:7]);
            seg_lim <= seed[9] ? addr + 32'(seed[12:10]) - 32'd1 : 32'hffff_fff0;
            last = {1'b0, addr} + {1'b0, bytes} - 33'd1;
            fault = (seed[8:7] != 2'd0) &&
                    (last > {1'b0, seed[9] ? addr + 32'(seed[12:10]) - 32'd1 : 32'hffff_fff0});
            rd = (seed[8:7] == 2'd1 || seed[8:7] == 2'd3) && !fault;
            ie_in <= seed[13];
            ie_type_in <= seed[17:14];
            e.ie = seed[13] | fault;
            e.ie_type = seed[17:14] | {3'b000, fault};
            e.addr = addr;
            seed = xorshift(seed);
            reg_a <= seed ^ 32'h0a;
            reg_b <= seed ^ 32'h0b;
            reg_c <= seed ^ 32'h0c;
            reg_d <= seed ^ 32'h0d;
            imm <= ~seed;
            eip <= seed + 32'd7;
            for (int k = 0; k < 4; k++) begin
                sel[k] = seed[3*k +: 3];
                if (sel[k] == 3'd6 && !rd) sel[k] = 3'd4; // No load data to select.
                case (sel[k])
                    3'd0: e.ops[k] = seed ^ 32'h0a;
                    3'd1: e.ops[k] = seed ^ 32'h0b;
                    3'd2: e.ops[k] = seed ^ 32'h0c;
                    3'd3: e.ops[k] = seed ^ 32'h0d;
                    3'd4: e.ops[k] = ~seed;
                    3'd5: e.ops[k] = seed + 32'd7;
                    3'd6: e.ops[k] = addr ^ RD_XOR;
                    default: e.ops[k] = addr;
                endcase
            end
            op1_sel <= mem_stage_pkg::op_src_e'(sel[0]);
            op2_sel <= mem_stage_pkg::op_src_e'(sel[1]);
            op3_sel <= mem_stage_pkg::op_src_e'(sel[2]);
            op4_sel <= mem_stage_pkg::op_src_e'(sel[3]);
            exp_rd_addr = addr;
            exp_rd_size = sz[1:0];
            exp_rd_en = rd;
            if (rd) exp_reads++;
            valid_in <= 1'b1;
            do @(posedge clk); while (stall);
            exp_q.push_back(e);
            if (seed[31:30] == 2'd0) begin
                valid_in <= 1'b0; // Bubble between instructions.
                @(posedge clk);
            end
        end
        valid_in <= 1'b0;
        while (consumed < NUM_INSTR) @(posedge clk);
        repeat (2) @(posedge clk);
        if (rd_reqs != exp_reads || exp_q.size() != 0) begin
            stop_run("Memory read count or instruction count does not match.");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: common/mem_stage_defines.svh
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// Datapath and address width.
`define MS_DATA_W 32

// Operand slots handed to execute.
`define MS_NUM_OPS 4

// Width of an operand-source code.
`define MS_SRC_W 3

// Segment-limit exception bit in ie_type.
`define MS_IE_SEG 0

`endif

// File: common/mem_stage_pkg.sv
`include "mem_stage_defines.svh"

package mem_stage_pkg;

    // Where an operand slot takes its value from.
    typedef enum logic [`MS_SRC_W-1:0] {
        SRC_REG_A    = 3'd0,
        SRC_REG_B    = 3'd1,
        SRC_REG_C    = 3'd2,
        SRC_REG_D    = 3'd3,
        SRC_IMM      = 3'd4,
        SRC_EIP      = 3'd5,
        SRC_MEM_DATA = 3'd6,
        SRC_MEM_ADDR = 3'd7
    } op_src_e;

    // Memory access type of the instruction.
    typedef enum logic [1:0] {
        RW_NONE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } mem_rw_e;

    // Access size; the byte count is 1, 2 or 4.
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } op_size_e;

endpackage

// File: common/operand_src_if.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

interface operand_src_if;
    logic [`MS_DATA_W-1:0] reg_a;
    logic [`MS_DATA_W-1:0] reg_b;
    logic [`MS_DATA_W-1:0] reg_c;
    logic [`MS_DATA_W-1:0] reg_d;
    logic [`MS_DATA_W-1:0] imm;
    logic [`MS_DATA_W-1:0] eip;
    logic [`MS_DATA_W-1:0] mem_data; // Load data from the cache port.
    logic [`MS_DATA_W-1:0] mem_addr; // Effective address after push adjust.

    modport src (
        output reg_a, reg_b, reg_c, reg_d,
        output imm, eip, mem_data, mem_addr
    );

    modport sel (
        input reg_a, reg_b, reg_c, reg_d,
        input imm, eip, mem_data, mem_addr
    );
endinterface

// File: mem_stage.f
+incdir+common
common/mem_stage_pkg.sv
common/operand_src_if.sv
verilog/mem_addr_gen.sv
operand_select/operand_select.sv
verilog/dcache_port.sv
verilog/stage_control.sv
verilog/mem_stage.sv
bench/mem_stage_tb.sv

// File: operand_select/operand_select.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module operand_select (
    operand_src_if.sel              src,
    input  mem_stage_pkg::op_src_e  sel,
    output logic [`MS_DATA_W-1:0]   value
);

    // All eight codes are defined, so the last arm closes the case.
    always_comb begin
        case (sel)
            mem_stage_pkg::SRC_REG_A:    value = src.reg_a;
            mem_stage_pkg::SRC_REG_B:    value = src.reg_b;
            mem_stage_pkg::SRC_REG_C:    value = src.reg_c;
            mem_stage_pkg::SRC_REG_D:    value = src.reg_d;
            mem_stage_pkg::SRC_IMM:      value = src.imm;
            mem_stage_pkg::SRC_EIP:      value = src.eip;
            mem_stage_pkg::SRC_MEM_DATA: value = src.mem_data; // Valid once the read is done.
            default:                     value = src.mem_addr;
        endcase
    end

endmodule

// File: verilog/dcache_port.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module dcache_port (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    accept,
    input  logic [`MS_DATA_W-1:0]   addr,
    input  mem_stage_pkg::op_size_e size,
    output logic                    busy,
    output logic [`MS_DATA_W-1:0]   rdata,
    output logic                    mem_req,
    output logic [`MS_DATA_W-1:0]   mem_addr,
    output mem_stage_pkg::op_size_e mem_size,
    input  logic                    mem_ack,
    input  logic [`MS_DATA_W-1:0]   mem_rdata
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQ     = 2'd1;
    localparam logic [1:0] ST_ACK_LOW = 2'd2;
    localparam logic [1:0] ST_DONE    = 2'd3;

    logic [1:0] state;

    // Stall the stage from the start cycle until the data is in.
    assign busy = (state == ST_IDLE && start) || state == ST_REQ || state == ST_ACK_LOW;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_REQ;
                        mem_req <= 1'b1;
                    end
                end
                ST_REQ: begin
                    if (mem_ack) begin
                        state   <= ST_ACK_LOW;
                        mem_req <= 1'b0; // Phase 3.
                    end
                end
                ST_ACK_LOW: begin
                    if (!mem_ack) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    if (accept) begin
                        state <= ST_IDLE; // Held instruction is not read again.
                    end
                end
            endcase
        end
    end

    // Address and size stay put for the whole handshake.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            mem_addr <= addr;
            mem_size <= size;
        end
        if (state == ST_REQ && mem_ack) begin
            rdata <= mem_rdata;
        end
    end

endmodule

// File: verilog/mem_addr_gen.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_addr_gen (
    input  logic [`MS_DATA_W-1:0]   mem_addr,
    input  mem_stage_pkg::op_size_e opsize,
    input  logic                    size_ovr_en,
    input  mem_stage_pkg::op_size_e size_ovr,
    input  logic                    is_push,
    input  logic [`MS_DATA_W-1:0]   seg_lim,
    input  mem_stage_pkg::mem_rw_e  mem_rw,
    output mem_stage_pkg::op_size_e eff_size,
    output logic [`MS_DATA_W-1:0]   eff_addr,
    output logic                    seg_fault
);

    logic [2:0]          nbytes;
    logic [`MS_DATA_W:0] last_byte; // One extra bit so a wrap past 4G still faults.

    // Override size wins over the decoded operand size.
    always_comb begin
        if (size_ovr_en) begin
            eff_size = size_ovr;
        end else begin
            eff_size = opsize;
        end
    end

    always_comb begin
        case (eff_size)
            mem_stage_pkg::SZ_BYTE: nbytes = 3'd1;
            mem_stage_pkg::SZ_WORD: nbytes = 3'd2;
            default:                nbytes = 3'd4;
        endcase
    end

    // Push writes below the current stack pointer.
    always_comb begin
        if (is_push) begin
            eff_addr = mem_addr - `MS_DATA_W'(nbytes);
        end else begin
            eff_addr = mem_addr;
        end
    end

    always_comb begin
        last_byte = {1'b0, eff_addr} + (`MS_DATA_W+1)'(nbytes) - 1'b1;
        seg_fault = (mem_rw != mem_stage_pkg::RW_NONE) &&
                    (last_byte > {1'b0, seg_lim}); // Only real accesses can fault.
    end

endmodule

// File: verilog/mem_stage.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  mem_stage_pkg::op_size_e opsize,
    input  logic                    size_ovr_en,
    input  mem_stage_pkg::op_size_e size_ovr,
    input  logic [`MS_DATA_W-1:0]   mem_addr_in,
    input  mem_stage_pkg::mem_rw_e  mem_rw,
    input  logic                    is_push,
    input  logic [`MS_DATA_W-1:0]   seg_lim,
    input  logic [`MS_DATA_W-1:0]   reg_a,
    input  logic [`MS_DATA_W-1:0]   reg_b,
    input  logic [`MS_DATA_W-1:0]   reg_c,
    input  logic [`MS_DATA_W-1:0]   reg_d,
    input  logic [`MS_DATA_W-1:0]   imm,
    input  logic [`MS_DATA_W-1:0]   eip,
    input  mem_stage_pkg::op_src_e  op1_sel,
    input  mem_stage_pkg::op_src_e  op2_sel,
    input  mem_stage_pkg::op_src_e  op3_sel,
    input  mem_stage_pkg::op_src_e  op4_sel,
    input  logic                    ie_in,
    input  logic [3:0]              ie_type_in,
    input  logic                    out_stall,
    input  logic                    mem_ack,
    input  logic [`MS_DATA_W-1:0]   mem_rdata,
    output logic                    mem_req,
    output logic [`MS_DATA_W-1:0]   mem_addr,
    output mem_stage_pkg::op_size_e mem_size,
    output logic                    stall,
    output logic                    valid_out,
    output logic [`MS_DATA_W-1:0]   op1,
    output logic [`MS_DATA_W-1:0]   op2,
    output logic [`MS_DATA_W-1:0]   op3,
    output logic [`MS_DATA_W-1:0]   op4,
    output logic [`MS_DATA_W-1:0]   addr_out,
    output logic                    ie_out,
    output logic [3:0]              ie_type_out
);

    mem_stage_pkg::op_size_e                  eff_size;
    logic [`MS_DATA_W-1:0]                    eff_addr;
    logic                                     seg_fault;
    logic                                     rd_start;
    logic                                     rd_busy;
    logic [`MS_DATA_W-1:0]                    rd_data;
    logic                                     accept;
    mem_stage_pkg::op_src_e                   op_sel [`MS_NUM_OPS];
    logic [`MS_NUM_OPS-1:0][`MS_DATA_W-1:0]   ops;
    logic [`MS_NUM_OPS-1:0][`MS_DATA_W-1:0]   ops_q;

    operand_src_if srcs ();

    assign srcs.reg_a    = reg_a;
    assign srcs.reg_b    = reg_b;
    assign srcs.reg_c    = reg_c;
    assign srcs.reg_d    = reg_d;
    assign srcs.imm      = imm;
    assign srcs.eip      = eip;
    assign srcs.mem_addr = eff_addr;
    assign srcs.mem_data = rd_data;

    mem_addr_gen u_addr_gen (
        .mem_addr    (mem_addr_in),
        .opsize      (opsize),
        .size_ovr_en (size_ovr_en),
        .size_ovr    (size_ovr),
        .is_push     (is_push),
        .seg_lim     (seg_lim),
        .mem_rw      (mem_rw),
        .eff_size    (eff_size),
        .eff_addr    (eff_addr),
        .seg_fault   (seg_fault)
    );

    // Faulting reads never reach the memory port.
    assign rd_start = valid_in && (mem_rw == mem_stage_pkg::RW_READ) && !seg_fault;

    dcache_port u_dcache_port (
        .clk       (clk),
        .rst       (rst),
        .start     (rd_start),
        .accept    (accept),
        .addr      (eff_addr),
        .size      (eff_size),
        .busy      (rd_busy),
        .rdata     (rd_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_size  (mem_size),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    assign op_sel[0] = op1_sel;
    assign op_sel[1] = op2_sel;
    assign op_sel[2] = op3_sel;
    assign op_sel[3] = op4_sel;

    for (genvar g = 0; g < `MS_NUM_OPS; g++) begin : g_op
        operand_select u_sel (
            .src   (srcs),
            .sel   (op_sel[g]),
            .value (ops[g])
        );
    end

    stage_control u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid_in    (valid_in),
        .out_stall   (out_stall),
        .mem_busy    (rd_busy),
        .seg_fault   (seg_fault),
        .ie_in       (ie_in),
        .ie_type_in  (ie_type_in),
        .ops_in      (ops),
        .eff_addr    (eff_addr),
        .stall       (stall),
        .accept      (accept),
        .valid_out   (valid_out),
        .ops_out     (ops_q),
        .addr_out    (addr_out),
        .ie_out      (ie_out),
        .ie_type_out (ie_type_out)
    );

    assign op1 = ops_q[0];
    assign op2 = ops_q[1];
    assign op3 = ops_q[2];
    assign op4 = ops_q[3];

endmodule

// File: verilog/stage_control.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module stage_control (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      valid_in,
    input  logic                                      out_stall,
    input  logic                                      mem_busy,
    input  logic                                      seg_fault,
    input  logic                                      ie_in,
    input  logic [3:0]                                ie_type_in,
    input  logic [`MS_NUM_OPS-1:0][`MS_DATA_W-1:0]    ops_in,
    input  logic [`MS_DATA_W-1:0]                     eff_addr,
    output logic                                      stall,
    output logic                                      accept,
    output logic                                      valid_out,
    output logic [`MS_NUM_OPS-1:0][`MS_DATA_W-1:0]    ops_out,
    output logic [`MS_DATA_W-1:0]                     addr_out,
    output logic                                      ie_out,
    output logic [3:0]                                ie_type_out
);

    logic [3:0] ie_type_nx;

    // Hold upstream while the read runs or execute is not taking the result.
    assign stall  = (valid_in && mem_busy) || (valid_out && out_stall);
    assign accept = valid_in && !stall;

    always_comb begin
        ie_type_nx = ie_type_in;
        ie_type_nx[`MS_IE_SEG] = ie_type_in[`MS_IE_SEG] | seg_fault; // Segment limit fault.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            ie_out    <= 1'b0;
        end else if (accept) begin
            valid_out <= 1'b1;
            ie_out    <= ie_in | seg_fault;
        end else if (!out_stall) begin
            valid_out <= 1'b0; // Bubble once execute drains.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ops_out     <= ops_in;
            addr_out    <= eff_addr;
            ie_type_out <= ie_type_nx;
        end
    end

endmodule
